// ==== hw/bridge_pkg.sv ====
/*
 * Shared vector types of the bridge.
 * Used by the RTL and by the testbench for flits, credits and link words.
 */

`include "bridge_consts.svh"

package bridge_pkg;

  //////////////////////////////
  // Flit and credit types
  //////////////////////////////

  // One flit payload word
  typedef logic [`BRIDGE_FLIT_W-1:0] flit_data_t;

  // A credit count, wide enough for a full queue
  typedef logic [`BRIDGE_CRED_W-1:0] credit_t;

  // Virtual channel select
  typedef logic vc_sel_t;

  localparam vc_sel_t VC_REQ = 1'b0;
  localparam vc_sel_t VC_RSP = 1'b1;

  //////////////////////////////
  // Link word types
  //////////////////////////////

  // Data part, {channel header, payload}
  typedef logic [`BRIDGE_LINK_DATA_W-1:0] link_data_t;

  // Side part, {data valid, credit channel, credit count}
  typedef logic [`BRIDGE_LINK_USER_W-1:0] link_user_t;

endpackage

// ==== hw/credit_sync.sv ====
/*
 * Per-channel credit stage on the send side.
 * Registers one ingress flit, tracks free slots in the remote queue and
 * counts credits owed back to the far side after local queue pops.
 */

`timescale 1ns/10ps
`include "bridge_consts.svh"

module credit_sync (
  input  logic                   clk_i,
  input  logic                   rst_i,
  // Ingress flit stream
  input  logic                   flit_valid_i,
  input  bridge_pkg::flit_data_t flit_data_i,
  output logic                   flit_ready_o,
  // Offer towards the arbiter
  output logic                   send_valid_o,
  output bridge_pkg::flit_data_t send_data_o,
  output logic                   send_cred_only_o,
  input  logic                   send_ready_i,
  // Credits owed to the far side
  output bridge_pkg::credit_t    owed_o,
  input  logic                   owed_clear_i,
  // Credits returned over the link
  input  logic                   cred_valid_i,
  input  bridge_pkg::credit_t    cred_i,
  // Egress handshake of the local receive queue
  input  logic                   pop_valid_i,
  input  logic                   pop_ready_i
);

  import bridge_pkg::*;

  flit_data_t flit_q;
  logic       full_q;
  logic       active_q;
  credit_t    rem_cred_q;
  credit_t    owed_q;
  logic       accept;
  logic       drain;
  logic       force_send;
  credit_t    cred_add;
  credit_t    pop_add;

  //////////////////////////////
  // Ingress and stage register
  //////////////////////////////

  // A flit reserves its remote slot when it enters the stage
  assign drain        = full_q & send_ready_i;
  assign flit_ready_o = active_q & (~full_q | send_ready_i) & (rem_cred_q != '0);
  assign accept       = flit_valid_i & flit_ready_o;

  //////////////////////////////
  // Offer to the arbiter
  //////////////////////////////

  // Idle stage with enough owed credits sends them on their own
  assign force_send       = ~full_q & (owed_q >= credit_t'(`BRIDGE_FORCE_THRESH));
  assign send_valid_o     = full_q | force_send;
  assign send_cred_only_o = ~full_q;
  assign send_data_o      = flit_q;
  assign owed_o           = owed_q;

  assign cred_add = cred_valid_i ? cred_i : '0;
  assign pop_add  = credit_t'(pop_valid_i & pop_ready_i);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      full_q     <= 1'b0;
      active_q   <= 1'b0;
      rem_cred_q <= credit_t'(`BRIDGE_NUM_CRED);
      owed_q     <= '0;
    end else begin
      // Ingress opens one cycle after reset
      active_q <= 1'b1;
      if (accept) begin
        full_q <= 1'b1;
      end else if (drain) begin
        full_q <= 1'b0;
      end
      rem_cred_q <= rem_cred_q - credit_t'(accept) + cred_add;
      // A pop on the clearing edge still counts
      owed_q <= (owed_clear_i ? '0 : owed_q) + pop_add;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      flit_q <= flit_data_i;
    end
  end

endmodule

// ==== hw/link_rx_demux.sv ====
/*
 * Receive-side decode of incoming link words.
 * Steers payloads to the receive queues and returned credits to the
 * credit stages, and answers the link with ready.
 */

`timescale 1ns/10ps

module link_rx_demux (
  // Link input
  input  logic                   link_valid_i,
  input  bridge_pkg::link_data_t link_data_i,
  input  bridge_pkg::link_user_t link_user_i,
  output logic                   link_ready_o,
  // Receive queue pushes
  output logic                   req_q_valid_o,
  input  logic                   req_q_ready_i,
  output logic                   rsp_q_valid_o,
  input  logic                   rsp_q_ready_i,
  output bridge_pkg::flit_data_t q_data_o,
  // Credit deliveries
  output logic                   req_cred_valid_o,
  output logic                   rsp_cred_valid_o,
  output bridge_pkg::credit_t    cred_o
);

  import bridge_pkg::*;

  vc_sel_t    data_ch;
  flit_data_t payload;
  logic       data_valid;
  vc_sel_t    cred_ch;
  credit_t    cred_cnt;
  logic       link_fire;

  assign {data_ch, payload}              = link_data_i;
  assign {data_valid, cred_ch, cred_cnt} = link_user_i;

  // Data words go to the queue named by their header
  assign req_q_valid_o = link_valid_i & data_valid & (data_ch == VC_REQ);
  assign rsp_q_valid_o = link_valid_i & data_valid & (data_ch == VC_RSP);
  assign q_data_o      = payload;

  // Credit-only words are always taken
  assign link_ready_o = ~data_valid | ((data_ch == VC_REQ) ? req_q_ready_i : rsp_q_ready_i);
  assign link_fire    = link_valid_i & link_ready_o;

  assign req_cred_valid_o = link_fire & (cred_ch == VC_REQ);
  assign rsp_cred_valid_o = link_fire & (cred_ch == VC_RSP);
  assign cred_o           = cred_cnt;

endmodule

// ==== hw/noc_link_bridge.sv ====
/*
 * Credit-based bridge between a two-channel NoC port and a serial link.
 * Send path is credit stage, arbiter, output register. Receive path is
 * demux, then one receive queue per channel.
 */

`timescale 1ns/10ps
`include "bridge_consts.svh"

module noc_link_bridge (
  input  logic                   clk_i,
  input  logic                   rst_i,
  // Ingress flits
  input  logic                   req_valid_i,
  input  bridge_pkg::flit_data_t req_data_i,
  output logic                   req_ready_o,
  input  logic                   rsp_valid_i,
  input  bridge_pkg::flit_data_t rsp_data_i,
  output logic                   rsp_ready_o,
  // Egress flits
  output logic                   req_valid_o,
  output bridge_pkg::flit_data_t req_data_o,
  input  logic                   req_ready_i,
  output logic                   rsp_valid_o,
  output bridge_pkg::flit_data_t rsp_data_o,
  input  logic                   rsp_ready_i,
  // Link out
  output logic                   link_valid_o,
  output bridge_pkg::link_data_t link_data_o,
  output bridge_pkg::link_user_t link_user_o,
  input  logic                   link_ready_i,
  // Link in
  input  logic                   link_valid_i,
  input  bridge_pkg::link_data_t link_data_i,
  input  bridge_pkg::link_user_t link_user_i,
  output logic                   link_ready_o
);

  import bridge_pkg::*;

  localparam int LINK_W = `BRIDGE_LINK_DATA_W + `BRIDGE_LINK_USER_W;

  logic              req_send_valid, rsp_send_valid;
  flit_data_t        req_send_data, rsp_send_data;
  logic              req_cred_only, rsp_cred_only;
  logic              req_send_ready, rsp_send_ready;
  credit_t           req_owed, rsp_owed;
  logic              req_owed_clear, rsp_owed_clear;
  logic              arb_valid, arb_ready;
  link_data_t        arb_data;
  link_user_t        arb_user;
  logic [LINK_W-1:0] link_out_word;
  logic              rx_req_valid, rx_req_ready;
  logic              rx_rsp_valid, rx_rsp_ready;
  flit_data_t        rx_data;
  logic              req_cred_valid, rsp_cred_valid;
  credit_t           rx_cred;

  //////////////////////////////
  // Send path
  //////////////////////////////

  credit_sync u_req_sync (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .flit_valid_i     (req_valid_i),
    .flit_data_i      (req_data_i),
    .flit_ready_o     (req_ready_o),
    .send_valid_o     (req_send_valid),
    .send_data_o      (req_send_data),
    .send_cred_only_o (req_cred_only),
    .send_ready_i     (req_send_ready),
    .owed_o           (req_owed),
    .owed_clear_i     (req_owed_clear),
    .cred_valid_i     (req_cred_valid),
    .cred_i           (rx_cred),
    .pop_valid_i      (req_valid_o),
    .pop_ready_i      (req_ready_i)
  );

  credit_sync u_rsp_sync (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .flit_valid_i     (rsp_valid_i),
    .flit_data_i      (rsp_data_i),
    .flit_ready_o     (rsp_ready_o),
    .send_valid_o     (rsp_send_valid),
    .send_data_o      (rsp_send_data),
    .send_cred_only_o (rsp_cred_only),
    .send_ready_i     (rsp_send_ready),
    .owed_o           (rsp_owed),
    .owed_clear_i     (rsp_owed_clear),
    .cred_valid_i     (rsp_cred_valid),
    .cred_i           (rx_cred),
    .pop_valid_i      (rsp_valid_o),
    .pop_ready_i      (rsp_ready_i)
  );

  vc_arbiter u_arbiter (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .req_valid_i      (req_send_valid),
    .req_data_i       (req_send_data),
    .req_cred_only_i  (req_cred_only),
    .req_owed_i       (req_owed),
    .req_ready_o      (req_send_ready),
    .req_owed_clear_o (req_owed_clear),
    .rsp_valid_i      (rsp_send_valid),
    .rsp_data_i       (rsp_send_data),
    .rsp_cred_only_i  (rsp_cred_only),
    .rsp_owed_i       (rsp_owed),
    .rsp_ready_o      (rsp_send_ready),
    .rsp_owed_clear_o (rsp_owed_clear),
    .out_valid_o      (arb_valid),
    .out_data_o       (arb_data),
    .out_user_o       (arb_user),
    .out_ready_i      (arb_ready)
  );

  // Holds the link word stable while the link stalls
  stream_fifo #(
    .DEPTH (2),
    .WIDTH (LINK_W)
  ) u_link_out (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (arb_valid),
    .ready_o (arb_ready),
    .data_i  ({arb_data, arb_user}),
    .valid_o (link_valid_o),
    .ready_i (link_ready_i),
    .data_o  (link_out_word)
  );

  assign {link_data_o, link_user_o} = link_out_word;

  //////////////////////////////
  // Receive path
  //////////////////////////////

  link_rx_demux u_rx_demux (
    .link_valid_i     (link_valid_i),
    .link_data_i      (link_data_i),
    .link_user_i      (link_user_i),
    .link_ready_o     (link_ready_o),
    .req_q_valid_o    (rx_req_valid),
    .req_q_ready_i    (rx_req_ready),
    .rsp_q_valid_o    (rx_rsp_valid),
    .rsp_q_ready_i    (rx_rsp_ready),
    .q_data_o         (rx_data),
    .req_cred_valid_o (req_cred_valid),
    .rsp_cred_valid_o (rsp_cred_valid),
    .cred_o           (rx_cred)
  );

  stream_fifo #(
    .DEPTH (`BRIDGE_NUM_CRED),
    .WIDTH (`BRIDGE_FLIT_W)
  ) u_req_q (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (rx_req_valid),
    .ready_o (rx_req_ready),
    .data_i  (rx_data),
    .valid_o (req_valid_o),
    .ready_i (req_ready_i),
    .data_o  (req_data_o)
  );

  stream_fifo #(
    .DEPTH (`BRIDGE_NUM_CRED),
    .WIDTH (`BRIDGE_FLIT_W)
  ) u_rsp_q (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (rx_rsp_valid),
    .ready_o (rx_rsp_ready),
    .data_i  (rx_data),
    .valid_o (rsp_valid_o),
    .ready_i (rsp_ready_i),
    .data_o  (rsp_data_o)
  );

endmodule

// ==== hw/stream_fifo.sv ====
/*
 * Valid/ready FIFO built as a circular buffer.
 * Serves as the link output register and as the per-channel receive queues.
 */

`timescale 1ns/10ps

module stream_fifo #(
  parameter int DEPTH = 2,
  parameter int WIDTH = 8
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             valid_i,
  output logic             ready_o,
  input  logic [WIDTH-1:0] data_i,
  output logic             valid_o,
  input  logic             ready_i,
  output logic [WIDTH-1:0] data_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  assign ready_o = (count_q != CNT_W'(DEPTH));
  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];
  assign push    = valid_i & ready_o;
  assign pop     = valid_o & ready_i;

  // Pointers wrap at DEPTH, so any depth works
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// ==== hw/vc_arbiter.sv ====
/*
 * Round-robin merge of the request and response offers into one link word.
 * Also picks the channel whose owed credits ride along in the word.
 */

`timescale 1ns/10ps

module vc_arbiter (
  input  logic                   clk_i,
  input  logic                   rst_i,
  // Request channel offer
  input  logic                   req_valid_i,
  input  bridge_pkg::flit_data_t req_data_i,
  input  logic                   req_cred_only_i,
  input  bridge_pkg::credit_t    req_owed_i,
  output logic                   req_ready_o,
  output logic                   req_owed_clear_o,
  // Response channel offer
  input  logic                   rsp_valid_i,
  input  bridge_pkg::flit_data_t rsp_data_i,
  input  logic                   rsp_cred_only_i,
  input  bridge_pkg::credit_t    rsp_owed_i,
  output logic                   rsp_ready_o,
  output logic                   rsp_owed_clear_o,
  // Merged link word
  output logic                   out_valid_o,
  output bridge_pkg::link_data_t out_data_o,
  output bridge_pkg::link_user_t out_user_o,
  input  logic                   out_ready_i
);

  import bridge_pkg::*;

  vc_sel_t    prio_q;
  vc_sel_t    data_ch;
  vc_sel_t    cred_ch;
  logic       grant_req;
  logic       grant_rsp;
  logic       out_fire;
  flit_data_t payload;
  logic       data_valid;
  credit_t    cred_cnt;

  //////////////////////////////
  // Grant
  //////////////////////////////

  // prio_q names the channel that wins when both offer
  assign grant_req = req_valid_i & (~rsp_valid_i | (prio_q == VC_REQ));
  assign grant_rsp = rsp_valid_i & ~grant_req;

  assign out_valid_o = req_valid_i | rsp_valid_i;
  assign out_fire    = out_valid_o & out_ready_i;
  assign req_ready_o = grant_req & out_ready_i;
  assign rsp_ready_o = grant_rsp & out_ready_i;

  //////////////////////////////
  // Link word
  //////////////////////////////

  assign data_ch    = grant_rsp ? VC_RSP : VC_REQ;
  assign payload    = grant_rsp ? rsp_data_i : req_data_i;
  assign data_valid = grant_rsp ? ~rsp_cred_only_i : ~req_cred_only_i;

  // Larger owed count rides along, response wins a tie
  assign cred_ch  = (req_owed_i > rsp_owed_i) ? VC_REQ : VC_RSP;
  assign cred_cnt = (cred_ch == VC_REQ) ? req_owed_i : rsp_owed_i;

  assign req_owed_clear_o = out_fire & (cred_ch == VC_REQ);
  assign rsp_owed_clear_o = out_fire & (cred_ch == VC_RSP);

  assign out_data_o = {data_ch, payload};
  assign out_user_o = {data_valid, cred_ch, cred_cnt};

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      prio_q <= VC_REQ;
    end else if (out_fire) begin
      prio_q <= (data_ch == VC_REQ) ? VC_RSP : VC_REQ;
    end
  end

endmodule

// ==== include/bridge_consts.svh ====
/*
 * Width and credit constants for the NoC to stream-link bridge.
 * Include this header wherever a width or a credit limit is needed.
 */

`ifndef BRIDGE_CONSTS_SVH
`define BRIDGE_CONSTS_SVH

// Flit payload width in bits
`define BRIDGE_FLIT_W 16

// Receive queue depth per channel, equal to the initial credit count
`define BRIDGE_NUM_CRED 8

// Credit field width, holds 0 to BRIDGE_NUM_CRED
`define BRIDGE_CRED_W 4

// Owed credits that force a credit-only word
`define BRIDGE_FORCE_THRESH 4

// Link word parts, channel header plus payload, and valid bit plus credit channel plus count
`define BRIDGE_LINK_DATA_W (`BRIDGE_FLIT_W + 1)
`define BRIDGE_LINK_USER_W (`BRIDGE_CRED_W + 2)

`endif

// ==== run_sim.sh ====
#!/bin/sh
# Builds the bridge testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f \
  --top-module bridge_tb \
  -o bridge_sim

./obj_dir/bridge_sim > sim.log 2>&1
cat sim.log

if grep -q "Finished with no errors" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

// ==== verification/bridge_properties.sv ====
/*
 * Concurrent assertions for the bridge, bound to the top level.
 * Covers link stability under stall, remote credit bounds and receive
 * queue overflow.
 */

`timescale 1ns/10ps
`include "bridge_consts.svh"

module bridge_properties (
  input logic                   clk_i,
  input logic                   rst_i,
  input logic                   out_valid_i,
  input logic                   out_ready_i,
  input bridge_pkg::link_data_t out_data_i,
  input bridge_pkg::link_user_t out_user_i,
  input logic                   rx_req_valid_i,
  input logic                   rx_req_ready_i,
  input logic                   rx_rsp_valid_i,
  input logic                   rx_rsp_ready_i,
  input bridge_pkg::credit_t    req_rem_cred_i,
  input bridge_pkg::credit_t    rsp_rem_cred_i
);

  import bridge_pkg::*;

  // Stalled link word keeps valid and its contents
  link_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    ($past(out_valid_i) && !$past(out_ready_i)) |->
      (out_valid_i && $stable(out_data_i) && $stable(out_user_i)))
    else $error("link word changed while stalled");

  req_cred_bound: assert property (@(posedge clk_i) disable iff (rst_i)
    req_rem_cred_i <= credit_t'(`BRIDGE_NUM_CRED))
    else $error("request remote credits above queue depth");

  rsp_cred_bound: assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_rem_cred_i <= credit_t'(`BRIDGE_NUM_CRED))
    else $error("response remote credits above queue depth");

  // Credits reserve room for every data word that reaches its queue
  rx_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
    !((rx_req_valid_i && !rx_req_ready_i) || (rx_rsp_valid_i && !rx_rsp_ready_i)))
    else $error("data word arrived at a full receive queue");

endmodule

bind noc_link_bridge bridge_properties u_properties (
  .clk_i          (clk_i),
  .rst_i          (rst_i),
  .out_valid_i    (link_valid_o),
  .out_ready_i    (link_ready_i),
  .out_data_i     (link_data_o),
  .out_user_i     (link_user_o),
  .rx_req_valid_i (rx_req_valid),
  .rx_req_ready_i (rx_req_ready),
  .rx_rsp_valid_i (rx_rsp_valid),
  .rx_rsp_ready_i (rx_rsp_ready),
  .req_rem_cred_i (u_req_sync.rem_cred_q),
  .rsp_rem_cred_i (u_rsp_sync.rem_cred_q)
);

// ==== verification/bridge_tb.sv ====
/*
 * Testbench for the NoC to stream-link bridge.
 * The link output is looped back to the link input through a two-entry model
 * link with random stalls. Flits accepted at ingress are checked at egress.
 */

`timescale 1ns/10ps
`include "bridge_consts.svh"

module bridge_tb;

  import bridge_pkg::*;

  localparam int LINK_W      = `BRIDGE_LINK_DATA_W + `BRIDGE_LINK_USER_W;
  localparam int TOTAL_FLITS = 10 + 2 * 24 + 16 + 4 * `BRIDGE_NUM_CRED + 2 * 20;
  localparam int CYCLE_LIMIT = 20 * TOTAL_FLITS + 200;

  logic       clk_i = 1'b0;
  logic       rst_i;
  logic       req_valid_i, req_ready_o, req_valid_o, req_ready_i;
  logic       rsp_valid_i, rsp_ready_o, rsp_valid_o, rsp_ready_i;
  flit_data_t req_data_i, rsp_data_i, req_data_o, rsp_data_o;
  logic       link_valid_o, link_ready_i, link_valid_i, link_ready_o;
  link_data_t link_data_o, link_data_i;
  link_user_t link_user_o, link_user_i;

  flit_data_t        req_exp[$];
  flit_data_t        rsp_exp[$];
  logic [LINK_W-1:0] model_q[$];
  logic [LINK_W-1:0] model_word;
  logic              model_push, model_pop;
  int req_acc = 0, req_del = 0, rsp_acc = 0, rsp_del = 0;
  int req_seq = 0, rsp_seq = 0, cycle_count = 0;
  int data_errs = 0, cred_errs = 0, other_errs = 0;
  bit egress_rand = 1'b0, link_stall = 1'b0, hold_req_low = 1'b0;

  noc_link_bridge dut (.*);

  always #5 clk_i = ~clk_i;

  //////////////////////////////
  // Reference and checks
  //////////////////////////////

  // Next expected flit of a channel, in ingress order
  function automatic flit_data_t expected_flit(input vc_sel_t ch);
    if (ch == VC_REQ) begin
      return req_exp.pop_front();
    end
    return rsp_exp.pop_front();
  endfunction

  function automatic credit_t in_flight(input int accepted, input int delivered);
    int diff;
    diff = accepted - delivered;
    if (diff < 0) diff = 0;
    if (diff > (1 << `BRIDGE_CRED_W) - 1) diff = (1 << `BRIDGE_CRED_W) - 1;
    return credit_t'(diff);
  endfunction

  task automatic check_flit(input string name, input flit_data_t exp, input flit_data_t act);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
      data_errs++;
    end
  endtask

  task automatic check_cred(input string name, input credit_t limit, input credit_t act);
    if (act > limit) begin
      $display("CHECK FAILED at %0t: %s expected at most %0d, got %0d", $time, name, limit, act);
      cred_errs++;
    end
  endtask

  task automatic print_counts();
    $display("Error counts: data %0d, credit %0d, other %0d", data_errs, cred_errs, other_errs);
  endtask

  // Handshakes are sampled mid-cycle where all signals are settled
  always @(negedge clk_i) begin
    if (!rst_i) begin
      if (req_valid_o && req_ready_i) begin
        if (req_exp.size() == 0) begin
          $display("Request flit %h at %0t was never sent", req_data_o, $time);
          other_errs++;
        end else begin
          check_flit("req_data_o", expected_flit(VC_REQ), req_data_o);
        end
        req_del++;
      end
      if (rsp_valid_o && rsp_ready_i) begin
        if (rsp_exp.size() == 0) begin
          $display("Response flit %h at %0t was never sent", rsp_data_o, $time);
          other_errs++;
        end else begin
          check_flit("rsp_data_o", expected_flit(VC_RSP), rsp_data_o);
        end
        rsp_del++;
      end
      check_cred("req flits in flight", credit_t'(`BRIDGE_NUM_CRED), in_flight(req_acc, req_del));
      check_cred("rsp flits in flight", credit_t'(`BRIDGE_NUM_CRED), in_flight(rsp_acc, rsp_del));
    end
  end

  //////////////////////////////
  // Link model and egress
  //////////////////////////////

  always begin
    @(negedge clk_i);
    model_push = link_valid_o && link_ready_i;
    model_pop  = link_valid_i && link_ready_o;
    model_word = {link_data_o, link_user_o};
    @(posedge clk_i);
    #1;
    if (model_pop) model_q.delete(0);
    if (model_push) model_q.push_back(model_word);
    link_valid_i = (model_q.size() != 0);
    {link_data_i, link_user_i} = (model_q.size() != 0) ? model_q[0] : '0;
    link_ready_i = (model_q.size() < 2) && (!link_stall || ($urandom % 2 == 0));
  end

  always @(posedge clk_i) begin
    #1;
    req_ready_i = !hold_req_low && (!egress_rand || ($urandom % 4 != 0));
    rsp_ready_i = !egress_rand || ($urandom % 4 != 0);
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: traffic did not drain within %0d cycles", CYCLE_LIMIT);
      other_errs++;
      print_counts();
      $display("Finished with errors");
      $finish;
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  // Offers count flits on one channel, valid and data hold until accepted
  task automatic send_flits(input vc_sel_t ch, input int count, input bit gaps);
    int         sent;
    bit         offering;
    bit         fire;
    flit_data_t flit;
    sent     = 0;
    offering = 1'b0;
    flit     = '0;
    while (sent < count) begin
      if (!offering && (!gaps || ($urandom % 3 != 0))) begin
        if (ch == VC_REQ) begin
          flit = {1'b0, 15'(req_seq)};
          req_seq++;
        end else begin
          flit = {1'b1, 15'(rsp_seq)};
          rsp_seq++;
        end
        offering = 1'b1;
      end
      if (ch == VC_REQ) begin
        req_valid_i = offering;
        req_data_i  = flit;
      end else begin
        rsp_valid_i = offering;
        rsp_data_i  = flit;
      end
      @(negedge clk_i);
      fire = offering && ((ch == VC_REQ) ? req_ready_o : rsp_ready_o);
      @(posedge clk_i);
      #1;
      if (fire) begin
        if (ch == VC_REQ) begin
          req_exp.push_back(flit);
          req_acc++;
        end else begin
          rsp_exp.push_back(flit);
          rsp_acc++;
        end
        sent++;
        offering = 1'b0;
      end
    end
    if (ch == VC_REQ) req_valid_i = 1'b0;
    else rsp_valid_i = 1'b0;
  endtask

  task automatic set_mode(input bit rand_egress, input bit stall, input bit hold_req);
    @(negedge clk_i);
    egress_rand  = rand_egress;
    link_stall   = stall;
    hold_req_low = hold_req;
    @(posedge clk_i);
    #1;
  endtask

  task automatic wait_drain();
    while (req_exp.size() != 0 || rsp_exp.size() != 0) @(posedge clk_i);
    repeat (4) @(posedge clk_i);
    #1;
  endtask

  initial begin
    int base;
    void'($urandom(32'hf3b03eff));
    rst_i        = 1'b1;
    req_valid_i  = 1'b0;
    req_data_i   = '0;
    rsp_valid_i  = 1'b0;
    rsp_data_i   = '0;
    req_ready_i  = 1'b0;
    rsp_ready_i  = 1'b0;
    link_ready_i = 1'b0;
    link_valid_i = 1'b0;
    link_data_i  = '0;
    link_user_i  = '0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    // Request flits alone
    send_flits(VC_REQ, 10, 1'b0);
    wait_drain();

    // Mixed traffic with random valids and egress ready
    set_mode(1'b1, 1'b0, 1'b0);
    fork
      send_flits(VC_REQ, 24, 1'b1);
      send_flits(VC_RSP, 24, 1'b1);
    join
    wait_drain();

    // Request egress held off until the credits run out
    set_mode(1'b0, 1'b0, 1'b1);
    base = req_acc;
    fork
      send_flits(VC_REQ, 16, 1'b0);
      begin
        while (req_acc < base + `BRIDGE_NUM_CRED) @(posedge clk_i);
        repeat (20) @(posedge clk_i);
        @(negedge clk_i);
        hold_req_low = 1'b0;
      end
    join
    wait_drain();

    // Long one-channel burst relies on credit-only words
    send_flits(VC_REQ, 4 * `BRIDGE_NUM_CRED, 1'b0);
    wait_drain();

    // Random link stalls on both channels
    set_mode(1'b1, 1'b1, 1'b0);
    fork
      send_flits(VC_REQ, 20, 1'b1);
      send_flits(VC_RSP, 20, 1'b1);
    join
    wait_drain();
    set_mode(1'b0, 1'b0, 1'b0);

    if (req_acc != req_del || rsp_acc != rsp_del) begin
      $display("Flit count mismatch: req sent %0d got %0d, rsp sent %0d got %0d",
               req_acc, req_del, rsp_acc, rsp_del);
      other_errs++;
    end
    print_counts();
    if (data_errs + cred_errs + other_errs == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+include
hw/bridge_pkg.sv
hw/stream_fifo.sv
hw/credit_sync.sv
hw/vc_arbiter.sv
hw/link_rx_demux.sv
hw/noc_link_bridge.sv
verification/bridge_properties.sv
verification/bridge_tb.sv
